/* common/lsu_pkg.sv */
// load/store unit types
// access size and load extension encodings as driven by the EX stage

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // access size
  ////////////////////////////////////////////////////////////

  // 2'b11 is decoded as a byte access as well
  typedef enum logic [1:0] {
    TYPE_WORD = 2'b00,  // 32 bit
    TYPE_HALF = 2'b01,  // 16 bit
    TYPE_BYTE = 2'b10   // 8 bit
  } data_type_e;

  ////////////////////////////////////////////////////////////
  // load extension
  ////////////////////////////////////////////////////////////

  // 2'b11 falls back to sign extension
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,  // fill upper bits with 0
    EXT_SIGN = 2'b01,  // replicate msb of loaded value
    EXT_ONE  = 2'b10   // fill upper bits with 1
  } ext_mode_e;

endpackage

/* common/lsu_settings.svh */
// load/store unit settings
// bus widths and the outstanding transaction limit shared by RTL and testbench

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data and address width of the bus
`define LSU_DATA_W 32

// one byte enable per byte lane
`define LSU_BE_W 4

// granted requests that may still wait for rvalid
`define LSU_MAX_OUTSTANDING 2

// counter must hold 0..LSU_MAX_OUTSTANDING
`define LSU_CNT_W 2

`endif

/* list.f */
+incdir+common
common/lsu_pkg.sv
rtl/lsu_req_gen.sv
rtl/lsu_txn_ctrl.sv
rtl/lsu_rdata_align.sv
rtl/load_store_unit.sv
verif/lsu_mem_model.sv
verif/tb_lsu.sv

/* rtl/load_store_unit.sv */
// load/store unit top
// connects request generation, transaction control and read data alignment
// to the EX stage and to a req/gnt + rvalid data bus

`timescale 1ns/10ps
`include "lsu_settings.svh"

module load_store_unit (
  input  logic                   clk,
  input  logic                   rst_n,

  // data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  output logic [`LSU_DATA_W-1:0] data_addr_o,
  output logic                   data_we_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,

  // EX stage
  input  logic                   data_we_ex_i,
  input  lsu_pkg::data_type_e    data_type_ex_i,
  input  logic [`LSU_DATA_W-1:0] data_wdata_ex_i,
  input  logic [1:0]             data_reg_offset_ex_i,
  input  lsu_pkg::ext_mode_e     data_sign_ext_ex_i,
  input  logic                   data_req_ex_i,
  input  logic [`LSU_DATA_W-1:0] operand_a_ex_i,
  input  logic [`LSU_DATA_W-1:0] operand_b_ex_i,
  input  logic                   addr_useincr_ex_i,
  input  logic                   data_misaligned_ex_i,  // second phase in EX
  output logic                   data_misaligned_o,     // to controller
  output logic [`LSU_DATA_W-1:0] data_rdata_ex_o,

  // stall and status
  output logic                   lsu_ready_ex_o,
  output logic                   lsu_ready_wb_o,
  output logic                   busy_o
);

  logic                   trans_valid;
  logic                   trans_ready;
  logic [`LSU_DATA_W-1:0] trans_addr;
  logic [`LSU_BE_W-1:0]   trans_be;
  logic [`LSU_DATA_W-1:0] trans_wdata;
  logic                   resp_valid;
  logic [`LSU_DATA_W-1:0] resp_rdata;
  logic                   ctrl_update;
  logic [1:0]             addr_lsb;     // offset for the WB registers

  ////////////////////////////////////////////////////////////
  // bus mapping
  ////////////////////////////////////////////////////////////

  // EX holds its inputs until grant, so requests are stable on the bus
  assign trans_ready  = data_gnt_i;
  assign data_req_o   = trans_valid;
  assign data_addr_o  = trans_addr;
  assign data_we_o    = data_we_ex_i;
  assign data_be_o    = trans_be;
  assign data_wdata_o = trans_wdata;
  assign resp_valid   = data_rvalid_i;
  assign resp_rdata   = data_rdata_i;

  lsu_req_gen u_req_gen (
    .operand_a_i       (operand_a_ex_i),
    .operand_b_i       (operand_b_ex_i),
    .addr_useincr_i    (addr_useincr_ex_i),
    .data_type_i       (data_type_ex_i),
    .data_reg_offset_i (data_reg_offset_ex_i),
    .data_wdata_i      (data_wdata_ex_i),
    .data_req_i        (data_req_ex_i),
    .data_misaligned_i (data_misaligned_ex_i),
    .addr_lsb_o        (addr_lsb),
    .data_misaligned_o (data_misaligned_o),
    .trans_addr_o      (trans_addr),
    .trans_be_o        (trans_be),
    .trans_wdata_o     (trans_wdata)
  );

  lsu_txn_ctrl u_txn_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_i     (data_req_ex_i),
    .trans_ready_i  (trans_ready),
    .resp_valid_i   (resp_valid),
    .trans_valid_o  (trans_valid),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .ctrl_update_o  (ctrl_update)
  );

  lsu_rdata_align u_rdata_align (
    .clk                  (clk),
    .rst_n                (rst_n),
    .ctrl_update_i        (ctrl_update),
    .data_type_i          (data_type_ex_i),
    .ext_mode_i           (data_sign_ext_ex_i),
    .data_we_i            (data_we_ex_i),
    .addr_lsb_i           (addr_lsb),
    .resp_valid_i         (resp_valid),
    .resp_rdata_i         (resp_rdata),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .data_rdata_o         (data_rdata_ex_o)
  );

endmodule

/* rtl/lsu_rdata_align.sv */
// lsu read data alignment
// keeps the WB copy of the access control, picks the addressed bytes out of
// the response, joins split loads with the held first beat and extends

`timescale 1ns/10ps
`include "lsu_settings.svh"

module lsu_rdata_align (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ctrl_update_i,         // EX access moves to WB
  input  lsu_pkg::data_type_e    data_type_i,
  input  lsu_pkg::ext_mode_e     ext_mode_i,
  input  logic                   data_we_i,
  input  logic [1:0]             addr_lsb_i,
  input  logic                   resp_valid_i,
  input  logic [`LSU_DATA_W-1:0] resp_rdata_i,
  input  logic                   data_misaligned_ex_i,  // EX is in second phase
  input  logic                   data_misaligned_i,     // EX first phase is split
  output logic [`LSU_DATA_W-1:0] data_rdata_o
);

  import lsu_pkg::*;

  data_type_e             data_type_q;
  logic [1:0]             rdata_offset_q;  // byte offset of the WB access
  ext_mode_e              ext_mode_q;
  logic                   data_we_q;       // stores return no data

  logic [`LSU_DATA_W-1:0] rdata_q;         // first beat or last result
  logic [`LSU_DATA_W-1:0] rdata_w_ext;     // word assembled from one or two beats
  logic [15:0]            rdata_h_raw;
  logic [7:0]             rdata_b_raw;
  logic [`LSU_DATA_W-1:0] data_rdata_ext;

  // fill the upper bits of a byte or halfword according to the mode
  function automatic logic [`LSU_DATA_W-1:0] extend_val(
    input logic [15:0] val,
    input logic        is_byte,
    input ext_mode_e   mode
  );
    logic                   fill;
    logic [`LSU_DATA_W-1:0] res;
    case (mode)
      EXT_ZERO: fill = 1'b0;
      EXT_ONE:  fill = 1'b1;
      default:  fill = is_byte ? val[7] : val[15];  // sign extension also for 2'b11
    endcase
    res = {{(`LSU_DATA_W-16){fill}}, val};
    if (is_byte) begin
      res[15:8] = {8{fill}};
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // WB control registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_type_q    <= TYPE_WORD;
      rdata_offset_q <= 2'b00;
      ext_mode_q     <= EXT_ZERO;
      data_we_q      <= 1'b0;
    end else if (ctrl_update_i) begin  // granted and now waiting on rvalid
      data_type_q    <= data_type_i;
      rdata_offset_q <= addr_lsb_i;
      ext_mode_q     <= ext_mode_i;
      data_we_q      <= data_we_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // byte selection
  ////////////////////////////////////////////////////////////

  // split word takes its low bytes from the held first beat
  always_comb begin
    case (rdata_offset_q)
      2'b00:   rdata_w_ext = resp_rdata_i;
      2'b01:   rdata_w_ext = {resp_rdata_i[7:0], rdata_q[`LSU_DATA_W-1:8]};
      2'b10:   rdata_w_ext = {resp_rdata_i[15:0], rdata_q[`LSU_DATA_W-1:16]};
      default: rdata_w_ext = {resp_rdata_i[23:0], rdata_q[`LSU_DATA_W-1:24]};
    endcase
  end

  always_comb begin
    case (rdata_offset_q)
      2'b00:   rdata_h_raw = resp_rdata_i[15:0];
      2'b01:   rdata_h_raw = resp_rdata_i[23:8];
      2'b10:   rdata_h_raw = resp_rdata_i[31:16];
      default: rdata_h_raw = {resp_rdata_i[7:0], rdata_q[31:24]};  // split half
    endcase
  end

  always_comb begin
    case (rdata_offset_q)
      2'b00:   rdata_b_raw = resp_rdata_i[7:0];
      2'b01:   rdata_b_raw = resp_rdata_i[15:8];
      2'b10:   rdata_b_raw = resp_rdata_i[23:16];
      default: rdata_b_raw = resp_rdata_i[31:24];
    endcase
  end

  // words are never extended
  always_comb begin
    case (data_type_q)
      TYPE_WORD: data_rdata_ext = rdata_w_ext;
      TYPE_HALF: data_rdata_ext = extend_val(rdata_h_raw, 1'b0, ext_mode_q);
      default:   data_rdata_ext = extend_val({8'h00, rdata_b_raw}, 1'b1, ext_mode_q);
    endcase
  end

  ////////////////////////////////////////////////////////////
  // held read data
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (resp_valid_i && !data_we_q) begin
      if (data_misaligned_ex_i || data_misaligned_i) begin
        rdata_q <= resp_rdata_i;    // raw beat merged on the next rvalid
      end else begin
        rdata_q <= data_rdata_ext;  // final value for the register file
      end
    end
  end

  assign data_rdata_o = resp_valid_i ? data_rdata_ext : rdata_q;

endmodule

/* rtl/lsu_req_gen.sv */
// lsu request generation
// forms the effective address, flags accesses that need a second beat,
// builds byte enables and rotates store data into its byte lanes

`timescale 1ns/10ps
`include "lsu_settings.svh"

module lsu_req_gen (
  input  logic [`LSU_DATA_W-1:0] operand_a_i,        // base from register file
  input  logic [`LSU_DATA_W-1:0] operand_b_i,        // offset or increment
  input  logic                   addr_useincr_i,     // 1 -> a + b, 0 -> a only
  input  lsu_pkg::data_type_e    data_type_i,
  input  logic [1:0]             data_reg_offset_i,  // byte offset inside store reg
  input  logic [`LSU_DATA_W-1:0] data_wdata_i,
  input  logic                   data_req_i,
  input  logic                   data_misaligned_i,  // second phase of split access
  output logic [1:0]             addr_lsb_o,
  output logic                   data_misaligned_o,  // first phase needs a second beat
  output logic [`LSU_DATA_W-1:0] trans_addr_o,
  output logic [`LSU_BE_W-1:0]   trans_be_o,
  output logic [`LSU_DATA_W-1:0] trans_wdata_o
);

  import lsu_pkg::*;

  logic [`LSU_DATA_W-1:0] data_addr_int;  // unaligned effective address
  logic [1:0]             wdata_offset;   // lane rotation for store data

  ////////////////////////////////////////////////////////////
  // address and misalignment
  ////////////////////////////////////////////////////////////

  assign data_addr_int = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_lsb_o    = data_addr_int[1:0];

  // second beat always targets the next word from lane 0
  assign trans_addr_o = data_misaligned_i ? {data_addr_int[`LSU_DATA_W-1:2], 2'b00}
                                          : data_addr_int;

  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_i) begin
      case (data_type_i)
        TYPE_WORD: data_misaligned_o = (data_addr_int[1:0] != 2'b00);
        TYPE_HALF: data_misaligned_o = (data_addr_int[1:0] == 2'b11);
        default:   data_misaligned_o = 1'b0;  // a byte never straddles words
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (data_type_i)
      TYPE_WORD: begin
        if (!data_misaligned_i) begin  // upper lanes of first word
          case (data_addr_int[1:0])
            2'b00:   trans_be_o = 4'b1111;
            2'b01:   trans_be_o = 4'b1110;
            2'b10:   trans_be_o = 4'b1100;
            default: trans_be_o = 4'b1000;
          endcase
        end else begin  // remaining low lanes of next word
          case (data_addr_int[1:0])
            2'b00:   trans_be_o = 4'b0000;  // aligned word has no second beat
            2'b01:   trans_be_o = 4'b0001;
            2'b10:   trans_be_o = 4'b0011;
            default: trans_be_o = 4'b0111;
          endcase
        end
      end

      TYPE_HALF: begin
        if (!data_misaligned_i) begin
          case (data_addr_int[1:0])
            2'b00:   trans_be_o = 4'b0011;
            2'b01:   trans_be_o = 4'b0110;
            2'b10:   trans_be_o = 4'b1100;
            default: trans_be_o = 4'b1000;  // low byte only, rest follows
          endcase
        end else begin
          trans_be_o = 4'b0001;  // only offset 3 splits a halfword
        end
      end

      default: begin  // byte, both codes
        case (data_addr_int[1:0])
          2'b00:   trans_be_o = 4'b0001;
          2'b01:   trans_be_o = 4'b0010;
          2'b10:   trans_be_o = 4'b0100;
          default: trans_be_o = 4'b1000;
        endcase
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////////////////////////

  // rotate left by (address offset - register offset) bytes
  assign wdata_offset = data_addr_int[1:0] - data_reg_offset_i;

  always_comb begin
    case (wdata_offset)
      2'b00:   trans_wdata_o = data_wdata_i;
      2'b01:   trans_wdata_o = {data_wdata_i[23:0], data_wdata_i[`LSU_DATA_W-1:24]};
      2'b10:   trans_wdata_o = {data_wdata_i[15:0], data_wdata_i[`LSU_DATA_W-1:16]};
      default: trans_wdata_o = {data_wdata_i[7:0], data_wdata_i[`LSU_DATA_W-1:8]};
    endcase
  end

endmodule

/* rtl/lsu_txn_ctrl.sv */
// lsu transaction control
// tracks granted requests still waiting for a response and derives
// request valid, EX/WB readiness, busy and the WB register update

`timescale 1ns/10ps
`include "lsu_settings.svh"

module lsu_txn_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_i,      // EX wants a bus access
  input  logic trans_ready_i,   // grant
  input  logic resp_valid_i,    // rvalid
  output logic trans_valid_o,
  output logic lsu_ready_ex_o,
  output logic lsu_ready_wb_o,
  output logic busy_o,
  output logic ctrl_update_o    // load WB control registers
);

  logic [`LSU_CNT_W-1:0] cnt_q;     // outstanding transactions
  logic [`LSU_CNT_W-1:0] next_cnt;
  logic                  count_up;  // request accepted this cycle
  logic                  count_down;

  ////////////////////////////////////////////////////////////
  // request and readiness
  ////////////////////////////////////////////////////////////

  // no path from rvalid to the request, the limit alone gates it
  assign trans_valid_o = data_req_i && (cnt_q < `LSU_MAX_OUTSTANDING);

  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : resp_valid_i;

  // with WB occupied, EX and WB may only advance together
  assign lsu_ready_ex_o = !data_req_i        ? 1'b1 :
                          (cnt_q == 2'd0)    ? (trans_valid_o && trans_ready_i) :
                          (cnt_q == 2'd1)    ? (resp_valid_i && trans_valid_o && trans_ready_i) :
                                               resp_valid_i;

  assign ctrl_update_o = lsu_ready_ex_o && data_req_i;

  assign busy_o = (cnt_q != '0) || trans_valid_o;  // counts a request still in flight

  ////////////////////////////////////////////////////////////
  // outstanding counter
  ////////////////////////////////////////////////////////////

  assign count_up   = trans_valid_o && trans_ready_i;
  assign count_down = resp_valid_i;  // responses come only for granted requests

  always_comb begin
    case ({count_up, count_down})
      2'b10:   next_cnt = cnt_q + 1'b1;
      2'b01:   next_cnt = cnt_q - 1'b1;
      default: next_cnt = cnt_q;  // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= next_cnt;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_lsu -o sim_lsu
out=$(./obj_dir/sim_lsu)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"

/* verif/lsu_mem_model.sv */
// data memory model for the lsu testbench
// word memory behind a req/gnt + rvalid bus, with grant stalls and
// an in-order response delay

`timescale 1ns/10ps
`include "lsu_settings.svh"

module lsu_mem_model (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic [`LSU_DATA_W-1:0] addr_i,
  input  logic                   we_i,
  input  logic [`LSU_BE_W-1:0]   be_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  input  logic [3:0]             gnt_stall_i,   // cycles a request waits for grant
  input  logic [3:0]             resp_delay_i,  // cycles from grant to rvalid, >= 1
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  logic [`LSU_DATA_W-1:0] mem [0:255];
  logic [3:0]             wait_q;       // cycles the current request has waited
  logic [31:0]            cycle_q;
  logic [`LSU_DATA_W-1:0] rdata_fifo[$];
  logic [31:0]            due_fifo[$];  // cycle in which each response is sent
  logic [7:0]             idx;

  // pattern covers the whole address, no two words alike
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'ha5c3_0f1e;
    end
  end

  assign gnt_o = req_i && (wait_q >= gnt_stall_i);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_q   <= '0;
      cycle_q  <= '0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      cycle_q <= cycle_q + 32'd1;
      if (gnt_o) begin
        wait_q <= '0;
        idx = addr_i[9:2];
        for (int b = 0; b < `LSU_BE_W; b++) begin
          if (we_i && be_i[b]) mem[idx][8*b +: 8] = wdata_i[8*b +: 8];
        end
        rdata_fifo.push_back(mem[idx]);
        due_fifo.push_back(cycle_q + 32'(resp_delay_i));
      end else if (req_i) begin
        wait_q <= wait_q + 4'd1;
      end
      // one response per cycle, oldest first
      if (due_fifo.size() > 0 && due_fifo[0] <= cycle_q) begin
        rvalid_o <= 1'b1;
        rdata_o  <= rdata_fifo.pop_front();
        void'(due_fifo.pop_front());
      end else begin
        rvalid_o <= 1'b0;
      end
    end
  end

endmodule

/* verif/tb_lsu.sv */
// load/store unit testbench
// stores, loads, split accesses, grant stalls and the outstanding limit

`timescale 1ns/10ps
`include "lsu_settings.svh"

module tb_lsu;

  import lsu_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int TIMEOUT    = 60;  // cycles per wait loop

  logic clk, rst_n;
  logic data_req, data_gnt, data_rvalid, data_we;
  logic [`LSU_DATA_W-1:0] data_addr, data_wdata, data_rdata, data_wdata_ex;
  logic [`LSU_BE_W-1:0] data_be;
  logic data_we_ex, data_req_ex, addr_useincr_ex, data_misaligned_ex;
  data_type_e data_type_ex;
  ext_mode_e data_sign_ext_ex;
  logic [1:0] data_reg_offset_ex;
  logic [`LSU_DATA_W-1:0] operand_a_ex, operand_b_ex, data_rdata_ex;
  logic data_misaligned, lsu_ready_ex, lsu_ready_wb, busy;
  logic [3:0] gnt_stall, resp_delay;

  int errors, tests_run, tests_failed, test_start_errors;
  int outstanding, max_outstanding, g_stalls;
  logic timed_out;
  string test_name;
  logic [31:0] g_addr, g_wdata, g_rdata;  // bus values seen at grant and the load result
  logic [3:0] g_be;
  logic g_misaligned;

  load_store_unit u_dut (
    .clk(clk), .rst_n(rst_n),
    .data_req_o(data_req), .data_gnt_i(data_gnt), .data_rvalid_i(data_rvalid),
    .data_addr_o(data_addr), .data_we_o(data_we), .data_be_o(data_be),
    .data_wdata_o(data_wdata), .data_rdata_i(data_rdata),
    .data_we_ex_i(data_we_ex), .data_type_ex_i(data_type_ex),
    .data_wdata_ex_i(data_wdata_ex), .data_reg_offset_ex_i(data_reg_offset_ex),
    .data_sign_ext_ex_i(data_sign_ext_ex), .data_req_ex_i(data_req_ex),
    .operand_a_ex_i(operand_a_ex), .operand_b_ex_i(operand_b_ex),
    .addr_useincr_ex_i(addr_useincr_ex), .data_misaligned_ex_i(data_misaligned_ex),
    .data_misaligned_o(data_misaligned), .data_rdata_ex_o(data_rdata_ex),
    .lsu_ready_ex_o(lsu_ready_ex), .lsu_ready_wb_o(lsu_ready_wb), .busy_o(busy)
  );

  lsu_mem_model u_mem (
    .clk(clk), .rst_n(rst_n), .req_i(data_req), .addr_i(data_addr), .we_i(data_we),
    .be_i(data_be), .wdata_i(data_wdata), .gnt_stall_i(gnt_stall),
    .resp_delay_i(resp_delay), .gnt_o(data_gnt), .rvalid_o(data_rvalid),
    .rdata_o(data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // granted but unanswered transactions as seen on the bus
  always @(posedge clk) begin
    if (rst_n) begin
      outstanding = outstanding + ((data_req && data_gnt) ? 1 : 0) - (data_rvalid ? 1 : 0);
      if (outstanding > max_outstanding) max_outstanding = outstanding;
      assert (outstanding <= `LSU_MAX_OUTSTANDING) else begin
        $display("%s: %0d transactions outstanding", test_name, outstanding);
        errors++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks and reference rules
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("%s: %s", test_name, msg);
      errors++;
    end
  endtask

  function automatic int size_bytes(input data_type_e dt);
    return (dt == TYPE_WORD) ? 4 : (dt == TYPE_HALF) ? 2 : 1;
  endfunction

  function automatic logic [31:0] rotl_bytes(input logic [31:0] d, input logic [1:0] n);
    return (d << (8 * n)) | (d >> (32 - 8 * n));
  endfunction

  // little endian bytes from the memory model starting at any address
  function automatic logic [31:0] mem_bytes(input logic [31:0] addr, input int n);
    logic [31:0] res;
    logic [31:0] a;
    res = '0;
    for (int k = 0; k < n; k++) begin
      a = addr + 32'(k);
      res[8*k +: 8] = u_mem.mem[a[9:2]][8*a[1:0] +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] extend_ref(input logic [31:0] raw, input int n,
                                             input ext_mode_e mode);
    logic fill;
    logic [31:0] res;
    if (n == 4) return raw;  // words are taken as they are
    case (mode)
      EXT_ZERO: fill = 1'b0;
      EXT_ONE:  fill = 1'b1;
      default:  fill = (n == 1) ? raw[7] : raw[15];
    endcase
    res = {32{fill}};
    if (n == 1) res[7:0] = raw[7:0];
    else res[15:0] = raw[15:0];
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // bus phases, each wait bounded
  ////////////////////////////////////////////////////////////

  // enters at a falling edge and returns a quarter period into the grant cycle
  task automatic wait_grant();
    logic [31:0] first_addr;
    g_stalls = 0;
    #(CLK_PERIOD/4);
    first_addr = data_addr;
    while (!(data_req && data_gnt) && !timed_out) begin
      check_true(data_req, "request dropped before grant");
      check_eq("stalled address", first_addr, data_addr);
      check_true(!lsu_ready_ex, "EX ready without grant");
      g_stalls++;
      if (g_stalls > TIMEOUT) begin
        $display("%s: no grant within %0d cycles", test_name, TIMEOUT);
        timed_out = 1'b1;
      end
      @(negedge clk);
      #(CLK_PERIOD/4);
    end
    g_addr       = data_addr;
    g_be         = data_be;
    g_wdata      = data_wdata;
    g_misaligned = data_misaligned;
  endtask

  task automatic wait_rvalid();
    int cycles;
    cycles = 0;
    #(CLK_PERIOD/4);
    while (!data_rvalid && cycles <= TIMEOUT) begin
      @(negedge clk);
      #(CLK_PERIOD/4);
      cycles++;
    end
    if (!data_rvalid) begin
      $display("%s: no response within %0d cycles", test_name, TIMEOUT);
      timed_out = 1'b1;
    end
    g_rdata = data_rdata_ex;  // valid in the rvalid cycle
    check_true(lsu_ready_wb, "WB not ready in response cycle");
  endtask

  // one bus access that starts and ends at a falling edge
  task automatic run_phase(input logic we, input data_type_e dt, input logic [31:0] addr,
                           input logic [1:0] reg_off, input logic [31:0] wdata,
                           input ext_mode_e mode, input logic second);
    data_we_ex         = we;
    data_type_ex       = dt;
    data_reg_offset_ex = reg_off;
    data_wdata_ex      = wdata;
    data_sign_ext_ex   = mode;
    operand_b_ex       = 32'($urandom_range(0, 255));
    operand_a_ex       = addr - operand_b_ex;  // adder path
    addr_useincr_ex    = 1'b1;
    data_misaligned_ex = second;
    data_req_ex        = 1'b1;
    wait_grant();
    if (timed_out) return;
    check_eq("write enable", 32'(we), 32'(data_we));
    @(negedge clk);
    data_req_ex        = 1'b0;
    data_misaligned_ex = g_misaligned;  // EX keeps a split access for its second phase
    wait_rvalid();
    @(negedge clk);
  endtask

  // both phases of a word or halfword access that crosses a word boundary
  task automatic split_access(input logic we, input data_type_e dt, input logic [31:0] addr,
                              input logic [31:0] wdata, input ext_mode_e mode);
    logic [3:0] be2;
    be2 = 4'((4'b0001 << (size_bytes(dt) - (4 - int'(addr[1:0])))) - 4'd1);
    run_phase(we, dt, addr, 2'd0, wdata, mode, 1'b0);
    check_eq("first phase flag", 32'd1, 32'(g_misaligned));
    check_eq("first phase be", 32'(4'((dt == TYPE_WORD ? 4'hf : 4'h3) << addr[1:0])),
             32'(g_be));
    if (we) check_eq("first phase wdata", rotl_bytes(wdata, addr[1:0]), g_wdata);
    if (timed_out) return;
    run_phase(we, dt, addr + 32'd4, 2'd0, wdata, mode, 1'b1);
    check_eq("second phase address", {addr[31:2] + 30'd1, 2'b00}, g_addr);
    check_eq("second phase be", 32'(be2), 32'(g_be));
    check_eq("second phase flag", 32'd0, 32'(g_misaligned));
    if (we) check_eq("second phase wdata", rotl_bytes(wdata, addr[1:0]), g_wdata);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_start_errors = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors != test_start_errors) tests_failed++;
    $display("test %-24s %s", test_name, (errors == test_start_errors) ? "ok" : "fail");
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    data_type_e  dt;
    ext_mode_e   mode;
    logic [1:0]  off, roff;
    logic [31:0] addr, wd, old, expv, rot;
    logic [3:0]  be_exp;
    int          cycles;
    void'($urandom(32'h686a_896b));
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    outstanding = 0;
    max_outstanding = 0;
    timed_out = 1'b0;
    test_name = "reset";
    rst_n = 1'b0;
    data_we_ex = 1'b0;
    data_type_ex = TYPE_WORD;
    data_wdata_ex = '0;
    data_reg_offset_ex = 2'd0;
    data_sign_ext_ex = EXT_ZERO;
    data_req_ex = 1'b0;
    operand_a_ex = '0;
    operand_b_ex = '0;
    addr_useincr_ex = 1'b0;
    data_misaligned_ex = 1'b0;
    gnt_stall = 4'd0;
    resp_delay = 4'd1;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    begin_test("aligned stores");
    #(CLK_PERIOD/4);
    check_true(!busy && lsu_ready_wb && !data_req, "idle state wrong after reset");
    @(negedge clk);
    for (int i = 0; i < 16 && !timed_out; i++) begin
      dt   = data_type_e'(2'($urandom_range(0, 2)));
      off  = (dt == TYPE_WORD) ? 2'd0 : (dt == TYPE_HALF) ? {1'($urandom_range(0, 1)), 1'b0}
                                                          : 2'($urandom_range(0, 3));
      roff = 2'($urandom_range(0, 3));
      addr = (32'($urandom_range(1, 250)) << 2) | 32'(off);
      wd   = $urandom();
      old  = u_mem.mem[addr[9:2]];
      rot  = rotl_bytes(wd, off - roff);
      be_exp = 4'((dt == TYPE_WORD ? 4'hf : dt == TYPE_HALF ? 4'h3 : 4'h1) << off);
      run_phase(1'b1, dt, addr, roff, wd, EXT_ZERO, 1'b0);
      check_eq("be", 32'(be_exp), 32'(g_be));
      check_eq("wdata", rot, g_wdata);
      check_eq("misaligned", 32'd0, 32'(g_misaligned));
      for (int b = 0; b < 4; b++) begin
        if (be_exp[b]) old[8*b +: 8] = rot[8*b +: 8];
      end
      check_eq("memory", old, u_mem.mem[addr[9:2]]);
    end
    end_test();

    begin_test("aligned loads");
    for (int i = 0; i < 18 && !timed_out; i++) begin
      mode = ext_mode_e'(2'(i % 3));
      dt   = data_type_e'(2'($urandom_range(0, 2)));
      off  = (dt == TYPE_WORD) ? 2'd0 : (dt == TYPE_HALF) ? 2'($urandom_range(0, 2))
                                                          : 2'($urandom_range(0, 3));
      addr = (32'($urandom_range(1, 250)) << 2) | 32'(off);
      resp_delay = 4'($urandom_range(1, 3));
      expv = extend_ref(mem_bytes(addr, size_bytes(dt)), size_bytes(dt), mode);
      run_phase(1'b0, dt, addr, 2'd0, 32'd0, mode, 1'b0);
      check_eq("load data", expv, g_rdata);
      #(CLK_PERIOD/4);
      check_eq("held load data", expv, data_rdata_ex);
      @(negedge clk);
    end
    end_test();

    begin_test("misaligned loads");
    resp_delay = 4'd2;
    for (int i = 0; i < 8 && !timed_out; i++) begin
      dt   = (i % 4 == 3) ? TYPE_HALF : TYPE_WORD;
      off  = (dt == TYPE_HALF) ? 2'd3 : 2'(i % 4 + 1);
      mode = ext_mode_e'(2'($urandom_range(0, 2)));
      addr = (32'($urandom_range(1, 250)) << 2) | 32'(off);
      expv = extend_ref(mem_bytes(addr, size_bytes(dt)), size_bytes(dt), mode);
      split_access(1'b0, dt, addr, 32'd0, mode);
      check_eq("load data", expv, g_rdata);
    end
    end_test();

    begin_test("misaligned stores");
    for (int i = 0; i < 8 && !timed_out; i++) begin
      dt   = (i % 4 == 3) ? TYPE_HALF : TYPE_WORD;
      off  = (dt == TYPE_HALF) ? 2'd3 : 2'(i % 4 + 1);
      addr = (32'($urandom_range(1, 250)) << 2) | 32'(off);
      wd   = $urandom();
      split_access(1'b1, dt, addr, wd, EXT_ZERO);
      check_eq("memory bytes", wd & (dt == TYPE_HALF ? 32'hffff : 32'hffff_ffff),
               mem_bytes(addr, size_bytes(dt)));
    end
    end_test();

    begin_test("grant back-pressure");
    gnt_stall = 4'd5;
    for (int i = 0; i < 3 && !timed_out; i++) begin
      addr = 32'($urandom_range(1, 250)) << 2;
      run_phase(1'b0, TYPE_WORD, addr, 2'd0, 32'd0, EXT_ZERO, 1'b0);
      check_eq("stall cycles", 32'd5, 32'(g_stalls));
      check_eq("load data", mem_bytes(addr, 4), g_rdata);
    end
    gnt_stall = 4'd0;
    end_test();

    begin_test("outstanding limit");
    if (!timed_out) begin
      resp_delay = 4'd8;
      max_outstanding = 0;
      data_we_ex = 1'b0;
      data_type_ex = TYPE_WORD;
      operand_a_ex = 32'h40;
      addr_useincr_ex = 1'b0;
      data_misaligned_ex = 1'b0;
      data_req_ex = 1'b1;
      for (int i = 0; i < 30; i++) begin
        #(CLK_PERIOD/4);
        if (outstanding > 0) check_true(busy, "busy low with transactions outstanding");
        @(negedge clk);
      end
      data_req_ex = 1'b0;
      cycles = 0;
      while (outstanding != 0 && cycles <= TIMEOUT) begin
        @(negedge clk);
        cycles++;
      end
      if (outstanding != 0) begin
        $display("%s: transactions never drained", test_name);
        timed_out = 1'b1;
      end
      #(CLK_PERIOD/4);
      check_eq("peak outstanding", 32'(`LSU_MAX_OUTSTANDING), 32'(max_outstanding));
      check_true(!busy && lsu_ready_wb, "busy or WB stall left after last response");
    end
    end_test();

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
